//--- logic/ilk_word_pkg.sv
package ilk_word_pkg;

	////////////////////////////////////////////////////////////////////////////
	// word format of the lane-bonded receive stream
	////////////////////////////////////////////////////////////////////////////

	// payload bits of one word
	localparam int word_bits = 64;

	// one input word is payload plus the control flag on top
	localparam int in_word_bits = word_bits + 1;

	// set for a control word, clear for data
	localparam int ctl_bit = 64;

	////////////////////////////////////////////////////////////////////////////
	// burst control word fields
	////////////////////////////////////////////////////////////////////////////

	// start of packet, applies to the next data word
	localparam int sop_bit = 63;

	// end of packet, applies to the previous data word
	localparam int eop_bit = 62;

	// low end of the 3-bit field: valid bytes of the last word minus one
	localparam int eop_bytes_lsb = 59;

	// per-word end mark, top bit is eop and the rest is the byte count minus one
	localparam int eopbits_w = 4;

	// unused bytes of a 16-byte output beat
	localparam int empty_w = 4;

	// control kind, encoded as {eop, sop} flag bits
	typedef enum logic [1:0] {
		ctl_idle    = 2'b00,
		ctl_sop     = 2'b01,
		ctl_eop     = 2'b10,
		ctl_eop_sop = 2'b11
	} ctl_kind_e;

endpackage

//--- logic/ilk_reg_pkg.sv
package ilk_reg_pkg;

	// apb bus widths
	localparam int apb_addr_w = 8;
	localparam int apb_data_w = 32;

	// each event counter saturates at all ones
	localparam int cnt_w = 16;

	// register map, byte addresses
	typedef enum logic [apb_addr_w-1:0] {
		reg_ctrl    = 8'h00,
		reg_pkt_cnt = 8'h04,
		reg_err_cnt = 8'h08,
		reg_ovf_cnt = 8'h0C
	} reg_addr_e;

endpackage

//--- logic/ilk_word_if.sv
`timescale 1ns/1ns

// one cycle of annotated words, index 1 is the upper word and first in time
interface ilk_word_if;

	// word payloads
	logic [1:0][ilk_word_pkg::word_bits-1:0] words;

	// one valid bit per word, no handshake
	logic [1:0] valid;

	// start of packet per word
	logic [1:0] sop;

	// end mark per word, {eop, bytes minus one}
	logic [1:0][ilk_word_pkg::eopbits_w-1:0] eopbits;

	modport src (
		output words,
		output valid,
		output sop,
		output eopbits
	);

	modport dst (
		input words,
		input valid,
		input sop,
		input eopbits
	);

endinterface

//--- logic/ilk_rx_annotate.sv
`timescale 1ns/1ns

module ilk_rx_annotate (
	input  logic clk,
	input  logic arst,
	input  logic [2*ilk_word_pkg::in_word_bits-1:0] din,
	input  logic din_valid,
	ilk_word_if.src out
);

	localparam int iw = ilk_word_pkg::in_word_bits;
	localparam int bw = ilk_word_pkg::eopbits_w - 1;

	// last data word, waiting for its follower
	logic held_vld;
	logic [ilk_word_pkg::word_bits-1:0] held_data;
	logic held_sop;

	// sop seen, no data word yet
	logic pend_sop;

	// next-state values after walking both input words
	logic nxt_vld;
	logic [ilk_word_pkg::word_bits-1:0] nxt_data;
	logic nxt_sop;
	logic nxt_pend;

	// words released this cycle, slot i is released by input word i
	logic [1:0] rel_vld;
	logic [1:0][ilk_word_pkg::word_bits-1:0] rel_data;
	logic [1:0] rel_sop;
	logic [1:0][ilk_word_pkg::eopbits_w-1:0] rel_eop;

	////////////////////////////////////////////////////////////////////////////
	// walk upper word then lower word
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		logic [iw-1:0] w;
		ilk_word_pkg::ctl_kind_e kind;
		nxt_vld  = held_vld;
		nxt_data = held_data;
		nxt_sop  = held_sop;
		nxt_pend = pend_sop;
		rel_vld  = '0;
		rel_data = '0;
		rel_sop  = '0;
		rel_eop  = '0;
		for (int i = 1; i >= 0; i--) begin
			w = din[i*iw +: iw];
			kind = ilk_word_pkg::ctl_kind_e'({w[ilk_word_pkg::eop_bit], w[ilk_word_pkg::sop_bit]});
			if (din_valid) begin
				// any arriving word pushes out the held one
				if (nxt_vld) begin
					rel_vld[i]  = 1'b1;
					rel_data[i] = nxt_data;
					rel_sop[i]  = nxt_sop;
					// eop lands on the word just before the control word
					if (w[ilk_word_pkg::ctl_bit] &&
						(kind == ilk_word_pkg::ctl_eop || kind == ilk_word_pkg::ctl_eop_sop)) begin
						rel_eop[i] = {1'b1, w[ilk_word_pkg::eop_bytes_lsb +: bw]};
					end
				end
				if (w[ilk_word_pkg::ctl_bit]) begin
					// control words are consumed here
					nxt_vld = 1'b0;
					if (kind == ilk_word_pkg::ctl_sop || kind == ilk_word_pkg::ctl_eop_sop) begin
						nxt_pend = 1'b1;
					end
				end else begin
					// data word takes any pending sop and waits
					nxt_vld  = 1'b1;
					nxt_data = w[ilk_word_pkg::word_bits-1:0];
					nxt_sop  = nxt_pend;
					nxt_pend = 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			held_vld  <= 1'b0;
			pend_sop  <= 1'b0;
			out.valid <= '0;
		end else begin
			held_vld  <= nxt_vld;
			pend_sop  <= nxt_pend;
			out.valid <= rel_vld;
		end
	end

	always_ff @(posedge clk) begin
		held_data   <= nxt_data;
		held_sop    <= nxt_sop;
		out.words   <= rel_data;
		out.sop     <= rel_sop;
		out.eopbits <= rel_eop;
	end

	// a sop from an earlier cycle must see a data word before any eop
	a_no_sop_eop: assert property (@(posedge clk) disable iff (arst)
		din_valid && pend_sop && din[iw + ilk_word_pkg::ctl_bit]
		|-> !din[iw + ilk_word_pkg::eop_bit])
		else $error("eop control word follows a sop with no data word between");

endmodule

//--- logic/ilk_rx_compact.sv
`timescale 1ns/1ns

module ilk_rx_compact (
	input  logic clk,
	input  logic arst,
	ilk_word_if.dst in_w,
	ilk_word_if.src out_w
);

	////////////////////////////////////////////////////////////////////////////
	// move a lone lower word into the upper slot
	////////////////////////////////////////////////////////////////////////////

	// only the valid mask is control state
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			out_w.valid <= '0;
		end else if (in_w.valid == 2'b01) begin
			out_w.valid <= 2'b10;
		end else begin
			// 00, 10 and 11 are already packed
			out_w.valid <= in_w.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_w.valid == 2'b01) begin
			// upper slot gets the lower word and the lower slot is cleared
			out_w.words[1]   <= in_w.words[0];
			out_w.sop[1]     <= in_w.sop[0];
			out_w.eopbits[1] <= in_w.eopbits[0];
			out_w.words[0]   <= '0;
			out_w.sop[0]     <= 1'b0;
			out_w.eopbits[0] <= '0;
		end else begin
			out_w.words   <= in_w.words;
			out_w.sop     <= in_w.sop;
			out_w.eopbits <= in_w.eopbits;
		end
	end

	// the lower slot is never valid on its own
	a_packed: assert property (@(posedge clk) disable iff (arst)
		out_w.valid[0] |-> out_w.valid[1])
		else $error("compacted mask has a lower word without an upper word");

endmodule

//--- logic/ilk_rx_regroup.sv
`timescale 1ns/1ns

module ilk_rx_regroup #(
	parameter int buf_words = 8
) (
	input  logic clk,
	input  logic arst,
	ilk_word_if.dst in_w,
	input  logic enable,
	output logic [2*ilk_word_pkg::word_bits-1:0] avl_dout,
	output logic avl_dout_sop,
	output logic avl_dout_eop,
	output logic avl_valid,
	output logic avl_error,
	output logic [ilk_word_pkg::empty_w-1:0] avl_empty,
	input  logic avl_ready,
	output logic overflow,
	output logic pkt_done,
	output logic pkt_err
);

	localparam int ptr_w = $clog2(buf_words);
	localparam int ew = ilk_word_pkg::eopbits_w;
	localparam logic [ptr_w+1:0] depth = (ptr_w+2)'(buf_words);

	// one buffered word with its marks
	typedef struct packed {
		logic sop;
		logic [ew-1:0] eopbits;
		logic err;
		logic [ilk_word_pkg::word_bits-1:0] data;
	} entry_t;

	entry_t mem [buf_words];

	// free-running counters, one extra bit tells full from empty
	logic [ptr_w:0] wr_cnt;
	logic [ptr_w:0] rd_cnt;
	logic [ptr_w:0] used;
	logic [ptr_w-1:0] wr_idx;
	logic [ptr_w-1:0] wr_idx1;
	logic [ptr_w-1:0] rd_idx;
	logic [ptr_w-1:0] rd_idx1;

	// write side packet tracking
	logic in_pkt;
	logic bad;
	logic drop;
	logic nxt_in_pkt;
	logic nxt_bad;
	logic nxt_drop;
	logic [1:0] we;
	logic [1:0] nw;
	entry_t wd0;
	entry_t wd1;
	logic err_evt;
	logic ovf_evt;

	// beat built from the buffer head
	entry_t w0;
	entry_t w1;
	logic beat_rdy;
	logic beat_two;
	logic [2*ilk_word_pkg::word_bits-1:0] b_data;
	logic b_sop;
	logic b_eop;
	logic b_err;
	logic [ilk_word_pkg::empty_w-1:0] b_empty;
	logic load;

	assign used    = wr_cnt - rd_cnt;
	assign wr_idx  = wr_cnt[ptr_w-1:0];
	assign wr_idx1 = wr_idx + 1'b1;
	assign rd_idx  = rd_cnt[ptr_w-1:0];
	assign rd_idx1 = rd_idx + 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// write side: filter the stream and store what fits
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		entry_t e;
		logic keep;
		logic w_eop;
		nxt_in_pkt = in_pkt;
		nxt_bad    = bad;
		nxt_drop   = drop;
		we      = '0;
		nw      = '0;
		wd0     = '0;
		wd1     = '0;
		err_evt = 1'b0;
		ovf_evt = 1'b0;
		// disabled, so nothing stored and no packet open
		if (!enable) begin
			nxt_in_pkt = 1'b0;
			nxt_drop   = 1'b0;
		end
		for (int i = 1; i >= 0; i--) begin
			w_eop  = in_w.eopbits[i][ew-1];
			e.sop     = in_w.sop[i];
			e.eopbits = in_w.eopbits[i];
			e.err     = 1'b0;
			e.data    = in_w.words[i];
			keep = 1'b0;
			if (in_w.valid[i] && enable) begin
				if (in_w.sop[i]) begin
					// sop inside a packet closes it; read side flags the beat
					err_evt = err_evt | nxt_in_pkt;
					nxt_bad = 1'b0;
					keep = 1'b1;
				end else if (!nxt_in_pkt) begin
					// stray data outside any packet
					err_evt = 1'b1;
				end else if (!nxt_drop) begin
					keep  = 1'b1;
					e.err = nxt_bad & w_eop;
				end
				if (keep && ({1'b0, used} + (ptr_w+2)'(nw)) >= depth) begin
					// no room, drop and flag the packet
					keep     = 1'b0;
					ovf_evt  = 1'b1;
					nxt_bad  = 1'b1;
					nxt_drop = in_pkt_start(in_w.sop[i], w_eop, nxt_drop);
				end else if (in_w.sop[i]) begin
					nxt_drop = 1'b0;
				end
				if (in_w.sop[i] || nxt_in_pkt) begin
					nxt_in_pkt = !w_eop;
				end
				if (w_eop) begin
					nxt_drop = 1'b0;
				end
				if (keep) begin
					if (nw == 2'd0) begin
						we[0] = 1'b1;
						wd0   = e;
					end else begin
						we[1] = 1'b1;
						wd1   = e;
					end
					nw = nw + 2'd1;
				end
			end
		end
	end

	// a dropped sop discards the rest of its packet
	function automatic logic in_pkt_start(input logic sop, input logic eop, input logic cur);
		in_pkt_start = (sop && !eop) ? 1'b1 : cur;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// read side: never pair an eop word with the next packet
	////////////////////////////////////////////////////////////////////////////

	assign w0 = mem[rd_idx];
	assign w1 = mem[rd_idx1];

	always_comb begin
		// single upper word by default
		b_data   = {w0.data, {ilk_word_pkg::word_bits{1'b0}}};
		b_sop    = w0.sop;
		b_eop    = w0.eopbits[ew-1];
		b_err    = w0.err;
		b_empty  = {1'b1, ~w0.eopbits[ew-2:0]};
		beat_two = 1'b0;
		beat_rdy = (used != '0) && w0.eopbits[ew-1];
		if (used[ptr_w:1] != '0 && !w0.eopbits[ew-1]) begin
			beat_rdy = 1'b1;
			if (w1.sop) begin
				// next packet started early, cut this one short
				b_eop   = 1'b1;
				b_err   = 1'b1;
				b_empty = ilk_word_pkg::empty_w'(8);
			end else begin
				beat_two = 1'b1;
				b_data   = {w0.data, w1.data};
				b_eop    = w1.eopbits[ew-1];
				b_err    = w1.err;
				b_empty  = w1.eopbits[ew-1] ? {1'b0, ~w1.eopbits[ew-2:0]} : '0;
			end
		end
	end

	// output register is free or being emptied
	assign load = beat_rdy && (!avl_valid || avl_ready);

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			wr_cnt    <= '0;
			rd_cnt    <= '0;
			in_pkt    <= 1'b0;
			bad       <= 1'b0;
			drop      <= 1'b0;
			avl_valid <= 1'b0;
			overflow  <= 1'b0;
			pkt_err   <= 1'b0;
			pkt_done  <= 1'b0;
		end else begin
			wr_cnt   <= wr_cnt + (ptr_w+1)'(nw);
			in_pkt   <= nxt_in_pkt;
			bad      <= nxt_bad;
			drop     <= nxt_drop;
			overflow <= ovf_evt;
			pkt_err  <= err_evt;
			pkt_done <= avl_valid & avl_ready & avl_dout_eop;
			if (load) begin
				rd_cnt    <= rd_cnt + (beat_two ? (ptr_w+1)'(2) : (ptr_w+1)'(1));
				avl_valid <= 1'b1;
			end else if (avl_ready) begin
				avl_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (we[0]) begin
			mem[wr_idx] <= wd0;
		end
		if (we[1]) begin
			mem[wr_idx1] <= wd1;
		end
		if (load) begin
			avl_dout     <= b_data;
			avl_dout_sop <= b_sop;
			avl_dout_eop <= b_eop;
			avl_error    <= b_err;
			avl_empty    <= b_empty;
		end
	end

	// stalled beat holds still
	a_stable: assert property (@(posedge clk) disable iff (arst)
		avl_valid && !avl_ready |=> avl_valid && $stable(avl_dout))
		else $error("avl_dout changed while stalled");

	a_level: assert property (@(posedge clk) disable iff (arst)
		{1'b0, used} <= depth)
		else $error("regroup buffer holds more than buf_words");

endmodule

//--- logic/ilk_rx_apb_regs.sv
`timescale 1ns/1ns

module ilk_rx_apb_regs (
	input  logic clk,
	input  logic arst,
	input  logic [ilk_reg_pkg::apb_addr_w-1:0] paddr,
	input  logic [ilk_reg_pkg::apb_data_w-1:0] pwdata,
	input  logic pwrite,
	input  logic psel,
	input  logic penable,
	output logic [ilk_reg_pkg::apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic pkt_done,
	input  logic pkt_err,
	input  logic ovf,
	output logic enable
);

	ilk_reg_pkg::reg_addr_e addr;
	logic acc;
	logic wr_en;
	logic mapped;

	// events and clears, index 0 packets, 1 errors, 2 overflows
	logic [2:0] ev;
	logic [2:0] clr;
	logic [ilk_reg_pkg::cnt_w-1:0] cnt [3];

	assign addr   = ilk_reg_pkg::reg_addr_e'(paddr);
	assign acc    = psel & penable;
	assign wr_en  = acc & pwrite;
	assign pready = 1'b1;
	assign ev     = {ovf, pkt_err, pkt_done};

	// any write to a counter address clears it, data ignored
	assign clr[0] = wr_en && addr == ilk_reg_pkg::reg_pkt_cnt;
	assign clr[1] = wr_en && addr == ilk_reg_pkg::reg_err_cnt;
	assign clr[2] = wr_en && addr == ilk_reg_pkg::reg_ovf_cnt;

	////////////////////////////////////////////////////////////////////////////
	// read mux
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		mapped = 1'b1;
		case (addr)
			ilk_reg_pkg::reg_ctrl:    prdata = ilk_reg_pkg::apb_data_w'(enable);
			ilk_reg_pkg::reg_pkt_cnt: prdata = ilk_reg_pkg::apb_data_w'(cnt[0]);
			ilk_reg_pkg::reg_err_cnt: prdata = ilk_reg_pkg::apb_data_w'(cnt[1]);
			ilk_reg_pkg::reg_ovf_cnt: prdata = ilk_reg_pkg::apb_data_w'(cnt[2]);
			default: begin
				prdata = '0;
				mapped = 1'b0;
			end
		endcase
	end

	// unmapped address errors in the access cycle
	assign pslverr = acc & ~mapped;

	////////////////////////////////////////////////////////////////////////////
	// control bit and saturating counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			enable <= 1'b1;
			for (int k = 0; k < 3; k++) begin
				cnt[k] <= '0;
			end
		end else begin
			if (wr_en && addr == ilk_reg_pkg::reg_ctrl) begin
				enable <= pwdata[0];
			end
			for (int k = 0; k < 3; k++) begin
				if (clr[k]) begin
					cnt[k] <= '0;
				end else if (ev[k] && cnt[k] != '1) begin
					cnt[k] <= cnt[k] + 1'b1;
				end
			end
		end
	end

endmodule

//--- logic/ilk_rx_packet_top.sv
`timescale 1ns/1ns

module ilk_rx_packet_top #(
	parameter int buf_words = 8
) (
	input  logic clk,
	input  logic arst,
	// two input words, upper first, bit 64 marks control
	input  logic [2*ilk_word_pkg::in_word_bits-1:0] din,
	input  logic din_valid,
	// streaming packet output
	output logic [2*ilk_word_pkg::word_bits-1:0] avl_dout,
	output logic avl_dout_sop,
	output logic avl_dout_eop,
	output logic avl_valid,
	output logic avl_error,
	output logic [ilk_word_pkg::empty_w-1:0] avl_empty,
	input  logic avl_ready,
	output logic overflow,
	// apb register port
	input  logic [ilk_reg_pkg::apb_addr_w-1:0] paddr,
	input  logic [ilk_reg_pkg::apb_data_w-1:0] pwdata,
	input  logic pwrite,
	input  logic psel,
	input  logic penable,
	output logic [ilk_reg_pkg::apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	// annotate to compact, compact to regroup
	ilk_word_if ann_w ();
	ilk_word_if cmp_w ();

	logic enable;
	logic pkt_done;
	logic pkt_err;

	ilk_rx_annotate u_annotate (
		.clk       (clk),
		.arst      (arst),
		.din       (din),
		.din_valid (din_valid),
		.out       (ann_w.src)
	);

	ilk_rx_compact u_compact (
		.clk   (clk),
		.arst  (arst),
		.in_w  (ann_w.dst),
		.out_w (cmp_w.src)
	);

	ilk_rx_regroup #(
		.buf_words (buf_words)
	) u_regroup (
		.clk          (clk),
		.arst         (arst),
		.in_w         (cmp_w.dst),
		.enable       (enable),
		.avl_dout     (avl_dout),
		.avl_dout_sop (avl_dout_sop),
		.avl_dout_eop (avl_dout_eop),
		.avl_valid    (avl_valid),
		.avl_error    (avl_error),
		.avl_empty    (avl_empty),
		.avl_ready    (avl_ready),
		.overflow     (overflow),
		.pkt_done     (pkt_done),
		.pkt_err      (pkt_err)
	);

	// overflow pulse doubles as the counter event
	ilk_rx_apb_regs u_regs (
		.clk      (clk),
		.arst     (arst),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.pwrite   (pwrite),
		.psel     (psel),
		.penable  (penable),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.pkt_done (pkt_done),
		.pkt_err  (pkt_err),
		.ovf      (overflow),
		.enable   (enable)
	);

endmodule

//--- dv/ilk_rx_tb.sv
`timescale 1ns/1ns

module ilk_rx_tb;

	localparam int buf_words = 8;
	localparam int iw = ilk_word_pkg::in_word_bits;
	localparam int aw = ilk_reg_pkg::apb_addr_w;
	localparam int dw = ilk_reg_pkg::apb_data_w;
	localparam int stream_limit = 4000;
	localparam int apb_limit = 16;
	localparam int eop_limit = 200;
	localparam logic [aw-1:0] unmapped_addr = 8'h10;

	// one expected or captured output beat
	typedef struct packed {
		logic [127:0] data;
		logic sop;
		logic eop;
		logic err;
		logic [3:0] empty;
	} beat_t;

	logic clk;
	logic arst;
	logic [2*iw-1:0] din;
	logic din_valid;
	logic [127:0] avl_dout;
	logic avl_dout_sop;
	logic avl_dout_eop;
	logic avl_valid;
	logic avl_error;
	logic [ilk_word_pkg::empty_w-1:0] avl_empty;
	logic avl_ready;
	logic overflow;
	logic [aw-1:0] paddr;
	logic [dw-1:0] pwdata;
	logic pwrite;
	logic psel;
	logic penable;
	logic [dw-1:0] prdata;
	logic pready;
	logic pslverr;

	// serialized input words, then din pairs, then the model's beats
	logic [iw-1:0] wq[$];
	logic [2*iw-1:0] din_q[$];
	beat_t exp_q[$];
	beat_t cap_q[$];

	// capture collects beats instead of comparing them
	bit capture;
	int cap_eops;
	int ovf_seen;
	int n_checks;
	int n_errors;

	ilk_rx_packet_top #(
		.buf_words (buf_words)
	) DUT (
		.clk          (clk),
		.arst         (arst),
		.din          (din),
		.din_valid    (din_valid),
		.avl_dout     (avl_dout),
		.avl_dout_sop (avl_dout_sop),
		.avl_dout_eop (avl_dout_eop),
		.avl_valid    (avl_valid),
		.avl_error    (avl_error),
		.avl_empty    (avl_empty),
		.avl_ready    (avl_ready),
		.overflow     (overflow),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.pwrite       (pwrite),
		.psel         (psel),
		.penable      (penable),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////////////////////

	task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic compare_beat(input beat_t got, input beat_t exp);
		check_eq(got.data, exp.data, "beat data");
		check_eq(128'(got.sop), 128'(exp.sop), "beat sop");
		check_eq(128'(got.eop), 128'(exp.eop), "beat eop");
		check_eq(128'(got.err), 128'(exp.err), "beat error");
		check_eq(128'(got.empty), 128'(exp.empty), "beat empty");
	endtask

	// outputs settle after the rising edge, so the falling edge sees the transfer
	always @(negedge clk) begin : monitor
		beat_t got;
		if (!arst) begin
			if (overflow) begin
				ovf_seen++;
			end
			if (avl_valid && avl_ready) begin
				got = {avl_dout, avl_dout_sop, avl_dout_eop, avl_error, avl_empty};
				if (capture) begin
					cap_q.push_back(got);
					if (got.eop) begin
						cap_eops++;
					end
				end else if (exp_q.size() == 0) begin
					n_errors++;
					$display("unexpected output beat at %0t while the model expects none", $time);
				end else begin
					compare_beat(got, exp_q.pop_front());
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus and model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [iw-1:0] ctl_word(input bit sop, input bit eop, input int nbytes);
		logic [iw-1:0] w;
		w = '0;
		w[ilk_word_pkg::ctl_bit] = 1'b1;
		w[ilk_word_pkg::sop_bit] = sop;
		w[ilk_word_pkg::eop_bit] = eop;
		// byte field holds count minus one
		if (eop) begin
			w[ilk_word_pkg::eop_bytes_lsb +: 3] = 3'(nbytes - 1);
		end
		return w;
	endfunction

	function automatic int rand_len();
		return 1 + int'($urandom % 9);
	endfunction

	function automatic int rand_bytes();
		return 1 + int'($urandom % 8);
	endfunction

	// sop control, data words, eop control; trunc leaves the eop off
	// a truncated packet must be odd so its last word sits alone in the upper half
	task automatic add_packet(input int n, input int nbytes, input bit trunc, input bit predict);
		logic [63:0] d[$];
		beat_t b;
		int i;
		wq.push_back(ctl_word(1'b1, 1'b0, 0));
		for (i = 0; i < n; i++) begin
			d.push_back({$urandom, $urandom});
			wq.push_back({1'b0, d[i]});
		end
		if (!trunc) begin
			wq.push_back(ctl_word(1'b0, 1'b1, nbytes));
		end
		i = 0;
		while (predict && i < n) begin
			b = '0;
			b.sop = (i == 0);
			if (i + 1 < n) begin
				// two words, upper first
				b.data = {d[i], d[i+1]};
				b.eop = (i + 2 == n) && !trunc;
				b.empty = b.eop ? 4'(8 - nbytes) : 4'd0;
				i += 2;
			end else begin
				// last word alone in the upper half
				b.data = {d[i], 64'h0};
				b.eop = 1'b1;
				b.err = trunc;
				b.empty = trunc ? 4'd8 : 4'(16 - nbytes);
				i += 1;
			end
			exp_q.push_back(b);
		end
	endtask

	task automatic add_idles();
		int k;
		int n;
		n = int'($urandom % 3);
		for (k = 0; k < n; k++) begin
			wq.push_back(ctl_word(1'b0, 1'b0, 0));
		end
	endtask

	// data outside a packet, pushed out by an idle
	task automatic add_stray();
		wq.push_back({1'b0, $urandom, $urandom});
		wq.push_back(ctl_word(1'b0, 1'b0, 0));
	endtask

	// two words per din cycle with the first in time on top
	task automatic serialize_words();
		logic [iw-1:0] hi;
		logic [iw-1:0] lo;
		if (wq.size() % 2 != 0) begin
			wq.push_back(ctl_word(1'b0, 1'b0, 0));
		end
		while (wq.size() != 0) begin
			hi = wq.pop_front();
			lo = wq.pop_front();
			din_q.push_back({hi, lo});
		end
	endtask

	// ready_mode 0 always ready, 1 random, 2 low until an overflow is seen
	task automatic run_stream(input bit half_rate, input int ready_mode);
		int cyc;
		int ovf0;
		cyc = 0;
		ovf0 = ovf_seen;
		while ((din_q.size() != 0 || exp_q.size() != 0) && cyc < stream_limit) begin
			@(posedge clk);
			#1;
			if (din_q.size() != 0 && (!half_rate || cyc % 2 == 0)) begin
				din = din_q.pop_front();
				din_valid = 1'b1;
			end else begin
				din = '0;
				din_valid = 1'b0;
			end
			case (ready_mode)
				0: avl_ready = 1'b1;
				1: avl_ready = ($urandom % 4) != 0;
				default: avl_ready = (ovf_seen != ovf0);
			endcase
			cyc++;
		end
		@(posedge clk);
		#1;
		din = '0;
		din_valid = 1'b0;
		avl_ready = 1'b1;
		if (cyc >= stream_limit) begin
			n_errors++;
			$display("stream did not drain within %0d cycles, %0d beats still missing",
				stream_limit, exp_q.size());
		end
	endtask

	task automatic wait_final_eop();
		int t;
		t = 0;
		while (cap_eops == 0 && t < eop_limit) begin
			@(posedge clk);
			t++;
		end
		if (cap_eops == 0) begin
			n_errors++;
			$display("no eop beat arrived within %0d cycles", eop_limit);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// apb access
	////////////////////////////////////////////////////////////////////////////

	task automatic apb_access(input logic [aw-1:0] addr, input bit wr, input logic [dw-1:0] wdata,
		output logic [dw-1:0] rdata, output logic err);
		int t;
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		t = 0;
		@(negedge clk);
		while (!pready && t < apb_limit) begin
			@(negedge clk);
			t++;
		end
		if (!pready) begin
			n_errors++;
			$display("apb access to %h got no pready within %0d cycles", addr, apb_limit);
		end
		// read data and error are valid in the access cycle
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [aw-1:0] addr, input logic [dw-1:0] data);
		logic [dw-1:0] rd;
		logic err;
		apb_access(addr, 1'b1, data, rd, err);
	endtask

	task automatic apb_read(input logic [aw-1:0] addr, output logic [dw-1:0] data, output logic err);
		apb_access(addr, 1'b0, '0, data, err);
	endtask

	task automatic clear_counters();
		apb_write(ilk_reg_pkg::reg_pkt_cnt, '0);
		apb_write(ilk_reg_pkg::reg_err_cnt, '0);
		apb_write(ilk_reg_pkg::reg_ovf_cnt, '0);
	endtask

	// event pulse is registered, then the counter
	task automatic settle_counters();
		idle_cycles(4);
	endtask

	task automatic report_test(input int num, input string name, input int err0);
		$display("test %0d %s: %0d errors", num, name, n_errors - err0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int err0;
		int ovf0;
		int p;
		int k;
		logic [dw-1:0] rd;
		logic slv;
		void'($urandom(32'hb872d7bd));
		clk = 1'b0;
		arst = 1'b1;
		din = '0;
		din_valid = 1'b0;
		avl_ready = 1'b1;
		paddr = '0;
		pwdata = '0;
		pwrite = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		capture = 1'b0;
		cap_eops = 0;
		ovf_seen = 0;
		n_checks = 0;
		n_errors = 0;
		repeat (8) @(posedge clk);
		#1;
		arst = 1'b0;

		// clean traffic at full rate
		err0 = n_errors;
		clear_counters();
		for (p = 0; p < 30; p++) begin
			add_packet(rand_len(), rand_bytes(), 1'b0, 1'b1);
			add_idles();
		end
		serialize_words();
		run_stream(1'b0, 0);
		settle_counters();
		apb_read(ilk_reg_pkg::reg_pkt_cnt, rd, slv);
		check_eq(128'(rd), 128'(30), "reg_pkt_cnt after clean traffic");
		report_test(1, "clean traffic", err0);

		// random back-pressure, input at half rate
		err0 = n_errors;
		ovf0 = ovf_seen;
		for (p = 0; p < 30; p++) begin
			add_packet(rand_len(), rand_bytes(), 1'b0, 1'b1);
			add_idles();
		end
		serialize_words();
		run_stream(1'b1, 1);
		check_eq(128'(ovf_seen - ovf0), 128'(0), "overflow pulses under back-pressure");
		report_test(2, "random ready", err0);

		// truncated packet, then a good one, then stray data
		err0 = n_errors;
		clear_counters();
		for (p = 0; p < 4; p++) begin
			k = 1 + 2 * int'($urandom % 4);
			add_packet(k, 8, 1'b1, 1'b1);
			add_idles();
			add_packet(rand_len(), rand_bytes(), 1'b0, 1'b1);
			add_stray();
			add_idles();
		end
		serialize_words();
		run_stream(1'b0, 0);
		settle_counters();
		apb_read(ilk_reg_pkg::reg_err_cnt, rd, slv);
		check_eq(128'(rd), 128'(8), "reg_err_cnt after malformed stream");
		report_test(3, "malformed stream", err0);

		// long packet into a stalled output
		err0 = n_errors;
		clear_counters();
		cap_q.delete();
		cap_eops = 0;
		capture = 1'b1;
		ovf0 = ovf_seen;
		add_packet(24, 5, 1'b0, 1'b0);
		serialize_words();
		run_stream(1'b0, 2);
		wait_final_eop();
		capture = 1'b0;
		settle_counters();
		check_eq(128'(ovf_seen != ovf0), 128'(1), "overflow pulse seen");
		apb_read(ilk_reg_pkg::reg_ovf_cnt, rd, slv);
		check_eq(128'(rd != 0), 128'(1), "reg_ovf_cnt nonzero");
		check_eq(128'(cap_eops), 128'(1), "eop beats of the overflowed packet");
		if (cap_q.size() != 0) begin
			check_eq(128'(cap_q[0].sop), 128'(1), "first beat sop");
			check_eq(128'(cap_q[cap_q.size()-1].eop), 128'(1), "final beat eop");
			check_eq(128'(cap_q[cap_q.size()-1].err), 128'(1), "final beat error");
		end
		report_test(4, "overflow", err0);

		// disabled path, counter clear, unmapped access
		err0 = n_errors;
		// a stray word gives the error counter something to clear
		add_stray();
		serialize_words();
		run_stream(1'b0, 0);
		settle_counters();
		apb_write(ilk_reg_pkg::reg_ctrl, '0);
		apb_read(ilk_reg_pkg::reg_ctrl, rd, slv);
		check_eq(128'(rd), 128'(0), "reg_ctrl after disable");
		for (p = 0; p < 5; p++) begin
			add_packet(rand_len(), rand_bytes(), 1'b0, 1'b0);
		end
		serialize_words();
		run_stream(1'b0, 0);
		// no beat may show up while disabled
		idle_cycles(30);
		apb_read(ilk_reg_pkg::reg_pkt_cnt, rd, slv);
		check_eq(128'(rd != 0), 128'(1), "reg_pkt_cnt before clear");
		apb_read(ilk_reg_pkg::reg_err_cnt, rd, slv);
		check_eq(128'(rd != 0), 128'(1), "reg_err_cnt before clear");
		apb_read(ilk_reg_pkg::reg_ovf_cnt, rd, slv);
		check_eq(128'(rd != 0), 128'(1), "reg_ovf_cnt before clear");
		clear_counters();
		apb_read(ilk_reg_pkg::reg_pkt_cnt, rd, slv);
		check_eq(128'(rd), 128'(0), "reg_pkt_cnt after clear");
		apb_read(ilk_reg_pkg::reg_err_cnt, rd, slv);
		check_eq(128'(rd), 128'(0), "reg_err_cnt after clear");
		apb_read(ilk_reg_pkg::reg_ovf_cnt, rd, slv);
		check_eq(128'(rd), 128'(0), "reg_ovf_cnt after clear");
		apb_read(unmapped_addr, rd, slv);
		check_eq(128'(slv), 128'(1), "pslverr on unmapped read");
		apb_read(ilk_reg_pkg::reg_ctrl, rd, slv);
		check_eq(128'(slv), 128'(0), "pslverr on mapped read");
		// traffic flows again once enabled
		apb_write(ilk_reg_pkg::reg_ctrl, 32'h1);
		add_packet(rand_len(), rand_bytes(), 1'b0, 1'b1);
		add_idles();
		add_packet(rand_len(), rand_bytes(), 1'b0, 1'b1);
		serialize_words();
		run_stream(1'b0, 0);
		settle_counters();
		apb_read(ilk_reg_pkg::reg_pkt_cnt, rd, slv);
		check_eq(128'(rd), 128'(2), "reg_pkt_cnt after enable");
		report_test(5, "registers", err0);

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- ilk_rx_packet.f
logic/ilk_word_pkg.sv
logic/ilk_reg_pkg.sv
logic/ilk_word_if.sv
logic/ilk_rx_annotate.sv
logic/ilk_rx_compact.sv
logic/ilk_rx_regroup.sv
logic/ilk_rx_apb_regs.sv
logic/ilk_rx_packet_top.sv
dv/ilk_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the regrouper testbench with verilator and run it
# the run counts as good only if the log holds the pass line

rm -f build.log sim.log

verilator --binary --timing --assert -f ilk_rx_packet.f --top-module ilk_rx_tb \
	-o ilk_rx_sim > build.log 2>&1 \
	&& ./obj_dir/ilk_rx_sim > sim.log 2>&1 \
	|| echo "build or simulation ended with an error status"

grep -qx "test passed" sim.log \
	&& echo "simulation finished without errors" \
	|| { echo "simulation reported failure, see sim.log and build.log"; exit 1; }
